//--- files.f
design/yaw_pkg.sv
design/yaw_if.sv
design/yaw_sequencer.sv
design/stick_conditioner.sv
design/heading_tracker.sv
design/heading_error.sv
design/yaw_angle_accumulator.sv
tb/tb_clock.sv
tb/yaw_assert.sv
tb/tb_yaw.sv

//--- Makefile
TOP := tb_yaw

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_yaw.sv
// Testbench for the yaw angle accumulator with LFSR stimulus, reference model and watchdog
`default_nettype none

module tb_yaw;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_ITER = 98;
	localparam int WATCHDOG_CYCLES = NUM_ITER * 20 + 200;
	localparam int COMPLETE_EDGES = 13;
	localparam int ACTIVE_FIRST_EDGE = 3;

	logic us_clk;
	logic resetn;
	logic start_signal;
	logic imu_ready;
	logic yaac_enable_n;
	yaw_pkg::rec_val_t throttle_pwm_value_input;
	yaw_pkg::rec_val_t yaw_pwm_value_input;
	yaw_pkg::angle_t yaw_angle_imu;
	yaw_pkg::angle_t body_yaw_angle_target;
	yaw_pkg::angle_t yaw_angle_error_out;
	logic yaw_stick_out_of_neutral_window;
	logic active_signal;
	logic complete_signal;

	bit [31:0] lfsr_state = 32'h7064_cef6;
	string test_name;
	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;

	// Reference state carried across iterations
	int m_neutral;
	int m_tracking;
	int m_prev_imu;
	int m_prev_err;

	tb_clock u_clock (.us_clk(us_clk));

	yaw_angle_accumulator dut0 (
		.us_clk                          (us_clk),
		.resetn                          (resetn),
		.start_signal                    (start_signal),
		.imu_ready                       (imu_ready),
		.yaac_enable_n                   (yaac_enable_n),
		.throttle_pwm_value_input        (throttle_pwm_value_input),
		.yaw_pwm_value_input             (yaw_pwm_value_input),
		.yaw_angle_imu                   (yaw_angle_imu),
		.body_yaw_angle_target           (body_yaw_angle_target),
		.yaw_angle_error_out             (yaw_angle_error_out),
		.yaw_stick_out_of_neutral_window (yaw_stick_out_of_neutral_window),
		.active_signal                   (active_signal),
		.complete_signal                 (complete_signal)
	);

	// Taps 32, 22, 2, 1
	function automatic bit lfsr_step();
		bit fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int value;
		int i;
		value = 0;
		for (i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr_step());
		end
		return value;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + (rand_bits(16) % (hi - lo + 1));
	endfunction

	function automatic yaw_pkg::rec_val_t rand_byte();
		return yaw_pkg::rec_val_t'(rand_bits(8));
	endfunction

	function automatic yaw_pkg::angle_t rand_angle();
		return yaw_pkg::angle_t'(rand_range(0, 5760));
	endfunction

	task automatic compare_angle(input string name, input yaw_pkg::angle_t got,
		input yaw_pkg::angle_t exp);
		test_checks++;
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_flag(input string name, input bit got, input bit exp);
		test_checks++;
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s = %0b, expected %0b", $time, name, got, exp);
			test_errors++;
		end
	endtask

	// One iteration of the accumulator, worked out in integers
	task automatic model_iteration(input yaw_pkg::rec_val_t thr, input yaw_pkg::rec_val_t yaw,
		input yaw_pkg::angle_t imu_in, input bit bypass,
		output int exp_target, output int exp_err, output bit exp_flag);
		int a360 = int'(yaw_pkg::ANGLE_360);
		int a270 = int'(yaw_pkg::ANGLE_270);
		int a90 = int'(yaw_pkg::ANGLE_90);
		int a360s = int'(yaw_pkg::ANGLE_360_SCALED);
		int window = int'(yaw_pkg::NEUTRAL_WINDOW);
		int imu;
		int stick;
		int sum;
		int target;
		int err;
		bit idle;
		idle = int'(thr) < int'(yaw_pkg::THROTTLE_IDLE);
		imu = int'(imu_in);
		if (imu > a360 || imu < 0) begin
			imu = m_prev_imu;
		end
		if (idle) begin
			m_neutral = int'(yaw);
		end
		stick = (int'(yaw) - m_neutral) * int'(yaw_pkg::STICK_GAIN);
		exp_flag = !idle && !(stick < window && stick > -window);
		sum = m_tracking + stick;
		if (idle) begin
			m_tracking = imu <<< yaw_pkg::SCALE_BITS;
		end else if (exp_flag) begin
			m_tracking = (sum > a360s) ? sum - a360s : (sum < 0) ? sum + a360s : sum;
		end
		target = idle ? imu : (m_tracking >>> yaw_pkg::SCALE_BITS);
		if (idle) begin
			err = 0;
		end else if (target > a270 && imu < a90) begin
			err = -(a360 - target + imu);
		end else if (imu > a270 && target < a90) begin
			err = a360 - imu + target;
		end else begin
			err = target - imu;
		end
		// Flip hold against last iteration
		if (m_prev_err >= a90 && err <= -a90) begin
			err = a90;
		end else if (m_prev_err <= -a90 && err >= a90) begin
			err = -a90;
		end
		m_prev_err = err;
		m_prev_imu = imu;
		exp_target = bypass ? int'(yaw) : target;
		exp_err = bypass ? 0 : (err > a90) ? a90 : (err < -a90) ? -a90 : err;
	endtask

	// Start pulse, wait for complete, check the published results
	task automatic run_iteration(input yaw_pkg::rec_val_t thr, input yaw_pkg::rec_val_t yaw,
		input yaw_pkg::angle_t imu, input bit bypass, output int edges);
		int exp_target;
		int exp_err;
		bit exp_flag;
		model_iteration(thr, yaw, imu, bypass, exp_target, exp_err, exp_flag);
		@(negedge us_clk);
		throttle_pwm_value_input = thr;
		yaw_pwm_value_input = yaw;
		yaw_angle_imu = imu;
		yaac_enable_n = bypass;
		start_signal = 1'b1;
		@(posedge us_clk);
		edges = 0;
		@(negedge us_clk);
		start_signal = 1'b0;
		while (!complete_signal && edges < 2 * COMPLETE_EDGES) begin
			@(posedge us_clk);
			edges++;
			@(negedge us_clk);
			// Active spans the cycles after edges 3 through 12
			compare_flag("active_signal", active_signal,
				edges >= ACTIVE_FIRST_EDGE && edges < COMPLETE_EDGES);
		end
		if (complete_signal) begin
			compare_angle("body_yaw_angle_target", body_yaw_angle_target,
				yaw_pkg::angle_t'(exp_target));
			compare_angle("yaw_angle_error_out", yaw_angle_error_out, yaw_pkg::angle_t'(exp_err));
			compare_flag("yaw_stick_out_of_neutral_window", yaw_stick_out_of_neutral_window,
				exp_flag);
		end else begin
			$display("No complete_signal within %0d edges of the start at %0d ns", edges, $time);
			test_checks++;
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		$display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		bit started;
		bit idle;
		int edges;
		int assert_failures;
		yaw_pkg::rec_val_t thr;
		yaw_pkg::rec_val_t yaw;
		yaw_pkg::angle_t imu;
		resetn = 1'b0;
		start_signal = 1'b0;
		imu_ready = 1'b0;
		yaac_enable_n = 1'b0;
		throttle_pwm_value_input = '0;
		yaw_pwm_value_input = '0;
		yaw_angle_imu = '0;
		repeat (5) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;

		begin_test("reset_and_imu_ready");
		compare_angle("body_yaw_angle_target", body_yaw_angle_target, '0);
		compare_angle("yaw_angle_error_out", yaw_angle_error_out, '0);
		compare_flag("yaw_stick_out_of_neutral_window", yaw_stick_out_of_neutral_window, 1'b0);
		start_signal = 1'b1;
		@(negedge us_clk);
		start_signal = 1'b0;
		started = 1'b0;
		repeat (20) begin
			@(negedge us_clk);
			started = started | active_signal | complete_signal;
		end
		test_checks++;
		if (started) begin
			$display("An iteration ran at %0d ns while imu_ready was low", $time);
			test_errors++;
		end
		imu_ready = 1'b1;
		repeat (2) @(negedge us_clk);
		end_test();

		begin_test("idle_throttle");
		repeat (8) begin
			thr = yaw_pkg::rec_val_t'(rand_range(0, 9));
			run_iteration(thr, rand_byte(), rand_angle(), 1'b0, edges);
		end
		end_test();

		begin_test("stick_tracking");
		repeat (40) begin
			thr = yaw_pkg::rec_val_t'(rand_range(10, 255));
			// About half the sticks sit near the captured neutral
			yaw = (rand_bits(1) == 1) ? yaw_pkg::rec_val_t'(m_neutral + rand_range(0, 10) - 5) :
				rand_byte();
			run_iteration(thr, yaw, rand_angle(), 1'b0, edges);
		end
		end_test();

		begin_test("seam_hold_clamp");
		repeat (30) begin
			idle = (rand_bits(3) == 0);
			thr = idle ? yaw_pkg::rec_val_t'(rand_range(0, 9)) :
				yaw_pkg::rec_val_t'(rand_range(10, 255));
			imu = (rand_bits(1) == 1) ? yaw_pkg::angle_t'(rand_range(0, 500)) :
				yaw_pkg::angle_t'(rand_range(5260, 5760));
			if (idle || rand_bits(2) == 0) begin
				imu = rand_angle();
			end
			run_iteration(thr, rand_byte(), imu, 1'b0, edges);
		end
		end_test();

		begin_test("imu_glitch");
		repeat (12) begin
			thr = (rand_bits(2) == 0) ? yaw_pkg::rec_val_t'(rand_range(0, 9)) :
				yaw_pkg::rec_val_t'(rand_range(10, 255));
			imu = (rand_bits(1) == 1) ? yaw_pkg::angle_t'(rand_range(5761, 32767)) :
				yaw_pkg::angle_t'(-rand_range(1, 32768));
			if (rand_bits(2) == 0) begin
				imu = rand_angle();
			end
			run_iteration(thr, rand_byte(), imu, 1'b0, edges);
		end
		end_test();

		begin_test("bypass");
		repeat (8) begin
			run_iteration(rand_byte(), rand_byte(), rand_angle(), 1'b1, edges);
			test_checks++;
			if (edges != COMPLETE_EDGES) begin
				$display("ERROR at %0d ns: complete_signal latency = %0d edges, expected %0d",
					$time, edges, COMPLETE_EDGES);
				test_errors++;
			end
		end
		end_test();

		assert_failures = dut0.u_sequencer.u_yaw_assert.fail_count;
		$display("Total: %0d checks, %0d errors, %0d assertion failures",
			total_checks, total_errors, assert_failures);
		if (total_errors == 0 && assert_failures == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/yaw_assert.sv
// Concurrent checks on the sequencer handshake, bound into yaw_sequencer
`default_nettype none

module yaw_assert (
	input wire                      us_clk,
	input wire                      resetn,
	input wire                      start_signal,
	input wire                      start_flag,
	input wire yaw_pkg::yaw_state_t state,
	input wire                      active_signal,
	input wire                      complete_signal
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// Complete is a single-cycle pulse
	complete_one_cycle: assert property (@(posedge us_clk) disable iff (!resetn)
		complete_signal |=> !complete_signal)
	else begin
		$error("complete_signal stayed high for more than one cycle");
		fail_count++;
	end

	active_complete_exclusive: assert property (@(posedge us_clk) disable iff (!resetn)
		!(active_signal && complete_signal))
	else begin
		$error("active_signal and complete_signal high together");
		fail_count++;
	end

	// Start accepted at edge 0 gives complete after edge 13
	complete_latency: assert property (@(posedge us_clk) disable iff (!resetn)
		$rose(complete_signal) |->
			$past(start_signal && state == yaw_pkg::waiting && !start_flag, 14))
	else begin
		$error("complete_signal did not rise 13 edges after start");
		fail_count++;
	end

endmodule

bind yaw_sequencer yaw_assert u_yaw_assert (
	.us_clk          (us_clk),
	.resetn          (resetn),
	.start_signal    (start_signal),
	.start_flag      (start_flag),
	.state           (state),
	.active_signal   (active_signal),
	.complete_signal (complete_signal)
);

`default_nettype wire

//--- tb/tb_clock.sv
// Free-running testbench clock with a 40 ns period
`default_nettype none

module tb_clock (
	output logic us_clk
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD = 20;

	initial begin
		us_clk = 1'b0;
		forever #(HALF_PERIOD) us_clk = ~us_clk;
	end

endmodule

`default_nettype wire

//--- design/yaw_angle_accumulator.sv
// Yaw angle accumulator top level with sequencer, conditioner, tracker and error blocks
`default_nettype none

module yaw_angle_accumulator (
	input  wire                    us_clk,
	input  wire                    resetn,
	input  wire                    start_signal,
	input  wire                    imu_ready,
	input  wire                    yaac_enable_n,
	input  wire yaw_pkg::rec_val_t throttle_pwm_value_input,
	input  wire yaw_pkg::rec_val_t yaw_pwm_value_input,
	input  wire yaw_pkg::angle_t   yaw_angle_imu,
	output yaw_pkg::angle_t        body_yaw_angle_target,
	output yaw_pkg::angle_t        yaw_angle_error_out,
	output logic                   yaw_stick_out_of_neutral_window,
	output logic                   active_signal,
	output logic                   complete_signal
);

	yaw_pkg::angle_t tracked_target;

	yaw_step_if step_bus ();
	yaw_meas_if meas_bus ();

	// Step order and handshake
	yaw_sequencer u_sequencer (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_signal    (start_signal),
		.imu_ready       (imu_ready),
		.active_signal   (active_signal),
		.complete_signal (complete_signal),
		.step            (step_bus.sequencer)
	);

	stick_conditioner u_stick_conditioner (
		.us_clk                   (us_clk),
		.resetn                   (resetn),
		.throttle_pwm_value_input (throttle_pwm_value_input),
		.yaw_pwm_value_input      (yaw_pwm_value_input),
		.yaw_angle_imu            (yaw_angle_imu),
		.step                     (step_bus.datapath),
		.meas                     (meas_bus.source)
	);

	heading_tracker u_heading_tracker (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.step          (step_bus.datapath),
		.meas          (meas_bus.sink),
		.out_of_window (yaw_stick_out_of_neutral_window),
		.target        (tracked_target)
	);

	// Error path and output registers
	heading_error u_heading_error (
		.us_clk                (us_clk),
		.resetn                (resetn),
		.yaac_enable_n         (yaac_enable_n),
		.target                (tracked_target),
		.step                  (step_bus.datapath),
		.meas                  (meas_bus.sink),
		.body_yaw_angle_target (body_yaw_angle_target),
		.yaw_angle_error_out   (yaw_angle_error_out)
	);

endmodule

`default_nettype wire

//--- design/heading_error.sv
// Heading error with seam correction, flip hold, clamp, bypass and output registers
`default_nettype none

module heading_error (
	input  wire                  us_clk,
	input  wire                  resetn,
	input  wire                  yaac_enable_n,
	input  wire yaw_pkg::angle_t target,
	yaw_step_if.datapath         step,
	yaw_meas_if.sink             meas,
	output yaw_pkg::angle_t      body_yaw_angle_target,
	output yaw_pkg::angle_t      yaw_angle_error_out
);

	yaw_pkg::angle_t err_raw;
	yaw_pkg::angle_t err;
	yaw_pkg::angle_t err_prev;
	yaw_pkg::angle_t err_clamped;

	// Limit the published error to +/-90 deg
	always_comb begin
		if (err > yaw_pkg::ANGLE_90) begin
			err_clamped = yaw_pkg::ANGLE_90;
		end else if (err < -yaw_pkg::ANGLE_90) begin
			err_clamped = -yaw_pkg::ANGLE_90;
		end else begin
			err_clamped = err;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			err_raw <= '0;
			err <= '0;
			err_prev <= '0;
			body_yaw_angle_target <= '0;
			yaw_angle_error_out <= '0;
		end else if (step.init_clear) begin
			err_raw <= '0;
			err <= '0;
			err_prev <= '0;
			body_yaw_angle_target <= '0;
			yaw_angle_error_out <= '0;
		end else begin
			if (step.error_raw) begin
				err_raw <= target - meas.imu_angle;
			end
			// Take the short way round when target and IMU straddle 0/360
			if (step.error_seam) begin
				if (meas.throttle_idle) begin
					err <= '0;
				end else if (target > yaw_pkg::ANGLE_270 && meas.imu_angle < yaw_pkg::ANGLE_90) begin
					err <= -(yaw_pkg::ANGLE_360 - target + meas.imu_angle);
				end else if (meas.imu_angle > yaw_pkg::ANGLE_270 && target < yaw_pkg::ANGLE_90) begin
					err <= yaw_pkg::ANGLE_360 - meas.imu_angle + target;
				end else begin
					err <= err_raw;
				end
			end
			// No sign flip across +/-90 deg from one iteration to the next
			if (step.error_hold) begin
				if (err_prev >= yaw_pkg::ANGLE_90 && err <= -yaw_pkg::ANGLE_90) begin
					err <= yaw_pkg::ANGLE_90;
				end else if (err_prev <= -yaw_pkg::ANGLE_90 && err >= yaw_pkg::ANGLE_90) begin
					err <= -yaw_pkg::ANGLE_90;
				end
			end
			if (step.error_out) begin
				err_prev <= err;
				// Disabled function passes the raw stick straight through
				if (yaac_enable_n) begin
					body_yaw_angle_target <= meas.yaw_raw;
					yaw_angle_error_out <= '0;
				end else begin
					body_yaw_angle_target <= target;
					yaw_angle_error_out <= err_clamped;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/heading_tracker.sv
// Neutral window flag, scaled heading accumulator with 360 deg wrap and target scale-down
`default_nettype none

module heading_tracker (
	input  wire              us_clk,
	input  wire              resetn,
	yaw_step_if.datapath     step,
	yaw_meas_if.sink         meas,
	output logic             out_of_window,
	output yaw_pkg::angle_t  target
);

	yaw_pkg::angle_t sum_q;
	yaw_pkg::angle_t tracking;
	logic            stick_neutral;

	assign stick_neutral = (meas.stick_norm < yaw_pkg::NEUTRAL_WINDOW) &&
		(meas.stick_norm > -yaw_pkg::NEUTRAL_WINDOW);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			out_of_window <= 1'b0;
		end else if (step.init_clear) begin
			out_of_window <= 1'b0;
		end else if (step.classify) begin
			out_of_window <= !meas.throttle_idle && !stick_neutral;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			sum_q <= '0;
			tracking <= '0;
			target <= '0;
		end else if (step.init_clear) begin
			sum_q <= '0;
			tracking <= '0;
			target <= '0;
		end else begin
			if (step.track_sum) begin
				sum_q <= tracking + meas.stick_norm;
			end
			// Idle throttle resyncs the accumulator to the IMU heading
			if (step.track_wrap) begin
				if (meas.throttle_idle) begin
					tracking <= meas.imu_angle <<< yaw_pkg::SCALE_BITS;
				end else if (!out_of_window) begin
					tracking <= tracking;
				end else if (sum_q > yaw_pkg::ANGLE_360_SCALED) begin
					tracking <= sum_q - yaw_pkg::ANGLE_360_SCALED;
				end else if (sum_q < 16'sd0) begin
					tracking <= sum_q + yaw_pkg::ANGLE_360_SCALED;
				end else begin
					tracking <= sum_q;
				end
			end
			if (step.scale) begin
				target <= meas.throttle_idle ? meas.imu_angle :
					(tracking >>> yaw_pkg::SCALE_BITS);
			end
		end
	end

endmodule

`default_nettype wire

//--- design/stick_conditioner.sv
// Input latch, IMU glitch filter, stick neutral capture and stick normalization
`default_nettype none

module stick_conditioner (
	input  wire                    us_clk,
	input  wire                    resetn,
	input  wire yaw_pkg::rec_val_t throttle_pwm_value_input,
	input  wire yaw_pkg::rec_val_t yaw_pwm_value_input,
	input  wire yaw_pkg::angle_t   yaw_angle_imu,
	yaw_step_if.datapath           step,
	yaw_meas_if.source             meas
);

	yaw_pkg::rec_val_t throttle_q;
	yaw_pkg::rec_val_t yaw_q;
	yaw_pkg::rec_val_t neutral_q;
	yaw_pkg::angle_t   imu_q;
	yaw_pkg::angle_t   imu_prev;
	yaw_pkg::angle_t   stick_q;
	yaw_pkg::angle_t   yaw_ext;
	yaw_pkg::angle_t   neutral_ext;
	logic              imu_glitch;

	// IMU readings outside 0..360 deg are garbage
	assign imu_glitch = (yaw_angle_imu > yaw_pkg::ANGLE_360) || (yaw_angle_imu < 16'sd0);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			throttle_q <= '0;
			yaw_q <= '0;
			imu_q <= '0;
		end else if (step.init_clear) begin
			throttle_q <= '0;
			yaw_q <= '0;
			imu_q <= '0;
		end else if (step.latch) begin
			throttle_q <= throttle_pwm_value_input;
			yaw_q <= yaw_pwm_value_input;
			imu_q <= imu_glitch ? imu_prev : yaw_angle_imu;
		end
	end

	// Last good angle, kept for the next iteration's glitch replacement
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			imu_prev <= '0;
		end else if (step.init_clear) begin
			imu_prev <= '0;
		end else if (step.error_out) begin
			imu_prev <= imu_q;
		end
	end

	// Stick rest position is learned only while the motors are idle
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			neutral_q <= '0;
		end else if (step.init_clear) begin
			neutral_q <= '0;
		end else if (step.neutral && meas.throttle_idle) begin
			neutral_q <= yaw_q;
		end
	end

	assign yaw_ext = {8'h00, yaw_q};
	assign neutral_ext = {8'h00, neutral_q};

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			stick_q <= '0;
		end else if (step.init_clear) begin
			stick_q <= '0;
		end else if (step.normalize) begin
			stick_q <= (yaw_ext - neutral_ext) * yaw_pkg::STICK_GAIN;
		end
	end

	assign meas.throttle_idle = (throttle_q < yaw_pkg::THROTTLE_IDLE);
	assign meas.stick_norm = stick_q;
	assign meas.imu_angle = imu_q;
	assign meas.yaw_raw = yaw_ext;

endmodule

`default_nettype wire

//--- design/yaw_sequencer.sv
// Start flag, iteration state machine, step strobe decode and active/complete handshake
`default_nettype none

module yaw_sequencer (
	input  wire             us_clk,
	input  wire             resetn,
	input  wire             start_signal,
	input  wire             imu_ready,
	output logic            active_signal,
	output logic            complete_signal,
	yaw_step_if.sequencer   step
);

	yaw_pkg::yaw_state_t state;
	yaw_pkg::yaw_state_t state_next;
	logic start_flag;
	logic active_next;

	// Start request stays pending until the FSM has left waiting
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
		end else if (start_signal) begin
			start_flag <= 1'b1;
		end else if (state != yaw_pkg::waiting) begin
			start_flag <= 1'b0;
		end
	end

	always_comb begin
		case (state)
			yaw_pkg::init:       state_next = imu_ready ? yaw_pkg::waiting : yaw_pkg::init;
			yaw_pkg::waiting:    state_next = start_flag ? yaw_pkg::latch : yaw_pkg::waiting;
			yaw_pkg::latch:      state_next = yaw_pkg::neutral;
			yaw_pkg::neutral:    state_next = yaw_pkg::normalize;
			yaw_pkg::normalize:  state_next = yaw_pkg::classify;
			yaw_pkg::classify:   state_next = yaw_pkg::track_sum;
			yaw_pkg::track_sum:  state_next = yaw_pkg::track_wrap;
			yaw_pkg::track_wrap: state_next = yaw_pkg::scale;
			yaw_pkg::scale:      state_next = yaw_pkg::error_raw;
			yaw_pkg::error_raw:  state_next = yaw_pkg::error_seam;
			yaw_pkg::error_seam: state_next = yaw_pkg::error_hold;
			yaw_pkg::error_hold: state_next = yaw_pkg::error_out;
			yaw_pkg::error_out:  state_next = yaw_pkg::complete;
			yaw_pkg::complete:   state_next = yaw_pkg::waiting;
			default:             state_next = yaw_pkg::init;
		endcase
	end

	// Active covers the steps after latch up to the output step
	assign active_next = state inside {yaw_pkg::neutral, yaw_pkg::normalize,
		yaw_pkg::classify, yaw_pkg::track_sum, yaw_pkg::track_wrap, yaw_pkg::scale,
		yaw_pkg::error_raw, yaw_pkg::error_seam, yaw_pkg::error_hold, yaw_pkg::error_out};

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= yaw_pkg::init;
			active_signal <= 1'b0;
			complete_signal <= 1'b0;
		end else begin
			state <= state_next;
			active_signal <= active_next;
			complete_signal <= (state == yaw_pkg::complete);
		end
	end

	// Each strobe is high for the one cycle its state lasts
	assign step.init_clear = (state == yaw_pkg::init);
	assign step.latch      = (state == yaw_pkg::latch);
	assign step.neutral    = (state == yaw_pkg::neutral);
	assign step.normalize  = (state == yaw_pkg::normalize);
	assign step.classify   = (state == yaw_pkg::classify);
	assign step.track_sum  = (state == yaw_pkg::track_sum);
	assign step.track_wrap = (state == yaw_pkg::track_wrap);
	assign step.scale      = (state == yaw_pkg::scale);
	assign step.error_raw  = (state == yaw_pkg::error_raw);
	assign step.error_seam = (state == yaw_pkg::error_seam);
	assign step.error_hold = (state == yaw_pkg::error_hold);
	assign step.error_out  = (state == yaw_pkg::error_out);

endmodule

`default_nettype wire

//--- design/yaw_if.sv
// Step strobe interface and measurement interface with their modports
`default_nettype none

// One-cycle step enables from the sequencer to the datapath blocks
interface yaw_step_if;
	logic init_clear;
	logic latch;
	logic neutral;
	logic normalize;
	logic classify;
	logic track_sum;
	logic track_wrap;
	logic scale;
	logic error_raw;
	logic error_seam;
	logic error_hold;
	logic error_out;

	modport sequencer (
		output init_clear, latch, neutral, normalize, classify, track_sum,
		output track_wrap, scale, error_raw, error_seam, error_hold, error_out
	);

	modport datapath (
		input init_clear, latch, neutral, normalize, classify, track_sum,
		input track_wrap, scale, error_raw, error_seam, error_hold, error_out
	);
endinterface

// Latched and conditioned inputs of the current iteration
interface yaw_meas_if;
	logic throttle_idle;
	yaw_pkg::angle_t stick_norm;
	yaw_pkg::angle_t imu_angle;
	yaw_pkg::angle_t yaw_raw;

	modport source (
		output throttle_idle, stick_norm, imu_angle, yaw_raw
	);

	modport sink (
		input throttle_idle, stick_norm, imu_angle, yaw_raw
	);
endinterface

`default_nettype wire

//--- design/yaw_pkg.sv
// Shared widths, angle types, angle constants and sequencer state enum
`default_nettype none

package yaw_pkg;

	localparam int REC_VAL_WIDTH = 8;
	localparam int ANGLE_WIDTH = 16;

	// Receiver value from the PWM decoder
	typedef logic [REC_VAL_WIDTH-1:0] rec_val_t;

	// Angle or rate in sixteenths of a degree, two's complement
	typedef logic signed [ANGLE_WIDTH-1:0] angle_t;

	// One state per step of an iteration
	typedef enum logic [3:0] {
		init,
		waiting,
		latch,
		neutral,
		normalize,
		classify,
		track_sum,
		track_wrap,
		scale,
		error_raw,
		error_seam,
		error_hold,
		error_out,
		complete
	} yaw_state_t;

	// 16 counts per degree
	localparam angle_t ANGLE_360 = 16'sd5760;
	localparam angle_t ANGLE_270 = 16'sd4320;
	localparam angle_t ANGLE_90 = 16'sd1440;

	// Tracking runs with two extra fraction bits
	localparam int SCALE_BITS = 2;
	localparam angle_t ANGLE_360_SCALED = 16'sd23040;

	localparam rec_val_t THROTTLE_IDLE = 8'd10;
	localparam angle_t NEUTRAL_WINDOW = 16'sd4;
	localparam angle_t STICK_GAIN = 16'sd1;

endpackage

`default_nettype wire
